// File: verilog/uc_config.svh
`ifndef UC_CONFIG_SVH
`define UC_CONFIG_SVH

// instruction and flag word
`define UC_WORD_WIDTH    16

// register file index, eight registers
`define UC_REG_IDX_WIDTH 3

// ALU operation code
`define UC_ALU_OP_WIDTH  4

// mod field value for a register operand
`define UC_MOD_REG       2'b11

`endif

// File: verilog/uc_pkg.sv
`default_nettype none

`include "uc_config.svh"

package uc_pkg;

    //////////////////////////////////////////////////
    // control steps
    typedef enum logic [7:0] {
        reset         = 8'h00,
        fetch0        = 8'h10,  // pc to address register
        fetch1        = 8'h11,
        fetch2        = 8'h12,  // ram word into ri
        decode        = 8'h20,
        addr_sum0     = 8'h30,  // [By+Xz]
        addr_sum1     = 8'h31,
        addr_sum2     = 8'h32,
        addr_reg      = 8'h34,  // [rm]
        load_src_reg  = 8'h40,
        load_src_mem0 = 8'h44,
        load_src_mem1 = 8'h45,
        load_src_mem2 = 8'h46,
        load_dst_reg  = 8'h50,
        load_dst_mem0 = 8'h54,
        load_dst_mem1 = 8'h55,
        load_dst_mem2 = 8'h56,
        exec_1op      = 8'h60,
        exec_2op      = 8'h64,
        store_reg     = 8'h70,
        store_mem0    = 8'h74,
        store_mem1    = 8'h75,
        inc_cp0       = 8'h80,
        inc_cp1       = 8'h81   // last step of every instruction
    } state_t;

    typedef enum logic [`UC_ALU_OP_WIDTH-1:0] {
        ADC, SBB1, SBB2, NOT, AND, OR, XOR, SHL, SHR, SAR
    } alu_op_t;

    typedef enum logic [`UC_REG_IDX_WIDTH-1:0] {
        RA, RB, RC, IS, XA, XB, BA, BB
    } reg_idx_t;

    // what the register file address is taken from
    typedef enum logic [2:0] {
        none, base, index, indirect, src, dst
    } addr_step_t;

    //////////////////////////////////////////////////
    // bundles
    typedef struct packed {
        logic [6:0] cop;   // bits 15..9
        logic       d;
        logic [1:0] mode;
        logic [2:0] rg;
        logic [2:0] rm;
    } instr_t;

    typedef struct packed {
        state_t src_step;
        state_t dst_step;
        state_t exec_step;
        state_t store_step;
        logic   dir;        // latched d bit
    } op_plan_t;

    typedef struct packed {
        logic    oe;
        logic    carry;
        alu_op_t opcode;
    } alu_ctrl_t;

    typedef struct packed {
        logic regs_oe;
        logic regs_we;
        logic ram_oe;
        logic ram_we;
        logic cp_oe;
        logic cp_we;
        logic ind_sel;  // flags input, 1 = alu flags
        logic ind_oe;
        logic ind_we;
        logic am_oe;
        logic am_we;
        logic t1_oe;
        logic t1_we;
        logic t2_oe;
        logic t2_we;
        logic ri_oe;
        logic ri_we;
    } bus_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "uc_config.svh"

module instr_decoder (
    input  logic             clk,
    input  logic             rst,
    input  uc_pkg::instr_t   ri,
    input  logic             decode_en,
    output uc_pkg::op_plan_t plan,
    output uc_pkg::state_t   entry_step
);
    import uc_pkg::*;

    logic     is_two_op;
    logic     is_one_op;
    logic     is_mov;
    logic     reg_mode;
    logic     is_reserved;
    logic     dir_next;
    logic     dst_in_reg;
    logic     src_in_reg;
    state_t   dst_load;
    op_plan_t plan_next;

    // instruction class
    assign is_two_op = ri.cop[5] && (ri.cop[2:0] != 3'b111);
    assign is_one_op = !ri.cop[5] && ri.cop[3] && (ri.cop[2:0] != 3'b111);
    assign is_mov    = !ri.cop[5] && !ri.cop[3] && (ri.cop[2:0] == 3'b000);  // push/pop excluded
    assign reg_mode  = (ri.mode == `UC_MOD_REG);

    // mod 01 and mod 10 are not supported
    assign is_reserved = !(is_two_op || is_one_op || is_mov)
                      || !(reg_mode || (ri.mode == 2'b00));

    assign dir_next   = is_one_op ? 1'b0 : ri.d;  // single operand always in rm
    assign dst_in_reg = reg_mode || dir_next;
    assign src_in_reg = reg_mode || !dir_next;
    assign dst_load   = dst_in_reg ? load_dst_reg : load_dst_mem0;

    always_comb begin
        plan_next.dir        = dir_next;
        plan_next.src_step   = src_in_reg ? load_src_reg : load_src_mem0;
        plan_next.dst_step   = dst_load;
        plan_next.exec_step  = exec_2op;
        plan_next.store_step = dst_in_reg ? store_reg : store_mem0;
        if (is_one_op) begin
            plan_next.src_step  = dst_load;  // no source operand, skip its load
            plan_next.exec_step = exec_1op;
        end else if (is_mov) begin
            plan_next.exec_step = exec_1op;
        end else if (!ri.cop[3]) begin
            plan_next.store_step = inc_cp0;  // CMP, TEST keep only the flags
        end
    end

    always_comb begin
        if (is_reserved) begin
            entry_step = reset;
        end else if (reg_mode) begin
            entry_step = plan_next.src_step;
        end else begin
            entry_step = ri.rm[0] ? addr_reg : addr_sum0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            plan <= '0;
        end else if (decode_en) begin
            plan <= plan_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/exec_op_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "uc_config.svh"

module exec_op_map (
    input  uc_pkg::instr_t          ri,
    input  logic [`UC_WORD_WIDTH-1:0] ind_flags,
    output uc_pkg::alu_ctrl_t       exec_alu,
    output logic                    flag_update,
    output logic                    mov_pass
);
    import uc_pkg::*;

    logic carry_flag;

    assign carry_flag = ind_flags[0];

    always_comb begin
        exec_alu    = '{oe: 1'b1, carry: 1'b0, opcode: OR};
        flag_update = 1'b1;
        mov_pass    = 1'b0;
        if (ri.cop[5]) begin
            case (ri.cop[2:0])
                3'b000: exec_alu.opcode = ADC;   // ADD
                3'b001: begin                    // ADC
                    exec_alu.opcode = ADC;
                    exec_alu.carry  = carry_flag;
                end
                3'b010: exec_alu.opcode = SBB1;  // SUB, CMP
                3'b011: begin                    // SBB
                    exec_alu.opcode = SBB1;
                    exec_alu.carry  = carry_flag;
                end
                3'b100: exec_alu.opcode = AND;   // AND, TEST
                3'b110: exec_alu.opcode = XOR;
                default: ;                       // OR
            endcase
        end else if (ri.cop[3]) begin
            case (ri.cop[2:0])
                3'b000: begin                    // INC
                    exec_alu.opcode = ADC;
                    exec_alu.carry  = 1'b1;
                end
                3'b001: begin                    // DEC
                    exec_alu.opcode = SBB1;
                    exec_alu.carry  = 1'b1;
                end
                3'b010: exec_alu.opcode = SBB2;  // NEG, 0 - t1
                3'b011: exec_alu.opcode = NOT;
                3'b100: exec_alu.opcode = SHL;   // SHL/SAL
                3'b101: exec_alu.opcode = SHR;
                default: exec_alu.opcode = SAR;
            endcase
        end else begin
            mov_pass    = 1'b1;  // t2 alone through OR
            flag_update = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/reg_addr_sel.sv
`timescale 1ns/1ps
`default_nettype none

module reg_addr_sel (
    input  uc_pkg::addr_step_t addr_step,
    input  logic               dir,
    input  uc_pkg::instr_t     ri,
    output uc_pkg::reg_idx_t   regs_addr
);
    import uc_pkg::*;

    reg_idx_t rg_idx;
    reg_idx_t rm_idx;

    assign rg_idx = reg_idx_t'(ri.rg);
    assign rm_idx = reg_idx_t'(ri.rm);

    always_comb begin
        case (addr_step)
            base:     regs_addr = ri.rm[1] ? BB : BA;
            index:    regs_addr = ri.rm[2] ? XB : XA;
            indirect: regs_addr = rm_idx;
            src:      regs_addr = dir ? rm_idx : rg_idx;
            dst:      regs_addr = dir ? rg_idx : rm_idx;
            default:  regs_addr = RA;  // nothing addressed
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/uc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module uc_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  uc_pkg::op_plan_t    plan,
    input  uc_pkg::state_t      entry_step,
    input  uc_pkg::alu_ctrl_t   exec_alu,
    input  logic                flag_update,
    input  logic                mov_pass,
    output logic                decode_en,
    output uc_pkg::addr_step_t  addr_step,
    output uc_pkg::bus_ctrl_t   bus,
    output uc_pkg::alu_ctrl_t   alu,
    output uc_pkg::state_t      state
);
    import uc_pkg::*;

    localparam alu_ctrl_t alu_pass_t1 = '{oe: 1'b1, carry: 1'b0, opcode: OR};
    localparam alu_ctrl_t alu_sum     = '{oe: 1'b1, carry: 1'b0, opcode: ADC};
    localparam alu_ctrl_t alu_inc     = '{oe: 1'b1, carry: 1'b1, opcode: ADC};

    state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= reset;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = reset;
        decode_en  = 1'b0;
        addr_step  = none;
        bus        = '0;
        alu        = '0;
        case (state)
            reset: state_next = fetch0;

            //////////////////////////////////////////////////
            // fetch and decode
            fetch0: begin
                bus.cp_oe  = 1'b1;
                bus.am_we  = 1'b1;
                state_next = fetch1;
            end
            fetch1: begin
                bus.am_oe  = 1'b1;
                state_next = fetch2;
            end
            fetch2: begin
                bus.ram_oe = 1'b1;
                bus.ri_we  = 1'b1;
                state_next = decode;
            end
            decode: begin
                decode_en  = 1'b1;
                state_next = entry_step;  // reset for reserved codes
            end

            //////////////////////////////////////////////////
            // address and operands
            addr_sum0: begin
                addr_step   = base;
                bus.regs_oe = 1'b1;
                bus.t1_we   = 1'b1;
                state_next  = addr_sum1;
            end
            addr_sum1: begin
                addr_step   = index;
                bus.regs_oe = 1'b1;
                bus.t2_we   = 1'b1;
                state_next  = addr_sum2;
            end
            addr_sum2: begin
                bus.t1_oe  = 1'b1;
                bus.t2_oe  = 1'b1;
                alu        = alu_sum;
                bus.t2_we  = plan.dir;   // address next to the memory operand
                bus.t1_we  = !plan.dir;
                state_next = plan.src_step;
            end
            addr_reg: begin
                addr_step   = indirect;
                bus.regs_oe = 1'b1;
                bus.t2_we   = plan.dir;
                bus.t1_we   = !plan.dir;
                state_next  = plan.src_step;
            end
            load_src_reg: begin
                addr_step   = src;
                bus.regs_oe = 1'b1;
                bus.t2_we   = 1'b1;
                state_next  = plan.dst_step;
            end
            load_src_mem0: begin
                bus.t2_oe  = 1'b1;
                alu        = '{oe: 1'b1, carry: 1'b0, opcode: OR};  // t2 to am
                bus.am_we  = 1'b1;
                state_next = load_src_mem1;
            end
            load_src_mem1: begin
                bus.am_oe  = 1'b1;
                state_next = load_src_mem2;
            end
            load_src_mem2: begin
                bus.ram_oe = 1'b1;
                bus.t2_we  = 1'b1;
                state_next = plan.dst_step;
            end
            load_dst_reg: begin
                addr_step   = dst;
                bus.regs_oe = 1'b1;
                bus.t1_we   = 1'b1;
                state_next  = plan.exec_step;
            end
            load_dst_mem0: begin
                bus.t1_oe  = 1'b1;
                alu        = alu_pass_t1;
                bus.am_we  = 1'b1;
                state_next = load_dst_mem1;
            end
            load_dst_mem1: begin
                bus.am_oe  = 1'b1;
                state_next = load_dst_mem2;
            end
            load_dst_mem2: begin
                bus.ram_oe = 1'b1;
                bus.t1_we  = 1'b1;
                state_next = plan.exec_step;
            end

            //////////////////////////////////////////////////
            // execute, store, next pc
            exec_1op, exec_2op: begin
                alu         = exec_alu;
                bus.t1_oe   = !mov_pass;
                bus.t2_oe   = mov_pass || (state == exec_2op);
                bus.t1_we   = 1'b1;     // result back into t1
                bus.ind_sel = flag_update;
                bus.ind_we  = flag_update;
                state_next  = plan.store_step;
            end
            store_reg: begin
                addr_step   = dst;
                bus.t1_oe   = 1'b1;
                alu         = alu_pass_t1;
                bus.regs_we = 1'b1;
                state_next  = inc_cp0;
            end
            store_mem0: begin
                bus.t1_oe  = 1'b1;
                alu        = alu_pass_t1;
                bus.am_oe  = 1'b1;      // am still holds the operand address
                bus.ram_we = 1'b1;
                state_next = store_mem1;
            end
            store_mem1: state_next = inc_cp0;
            inc_cp0: begin
                bus.cp_oe  = 1'b1;
                bus.t1_we  = 1'b1;
                state_next = inc_cp1;
            end
            inc_cp1: begin
                bus.t1_oe  = 1'b1;
                alu        = alu_inc;
                bus.cp_we  = 1'b1;
                state_next = fetch0;
            end
            default: state_next = reset;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/uc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uc_config.svh"

module uc_top (
    input  logic                      clk,
    input  logic                      rst,
    input  uc_pkg::instr_t            ri,
    input  logic [`UC_WORD_WIDTH-1:0] ind_flags,
    output uc_pkg::bus_ctrl_t         bus,
    output uc_pkg::alu_ctrl_t         alu,
    output uc_pkg::reg_idx_t          regs_addr,
    output uc_pkg::state_t            disp_state
);
    import uc_pkg::*;

    op_plan_t   plan;
    state_t     entry_step;
    logic       decode_en;
    alu_ctrl_t  exec_alu;
    logic       flag_update;
    logic       mov_pass;
    addr_step_t addr_step;

    instr_decoder instr_decoder_inst (
        .clk        (clk),
        .rst        (rst),
        .ri         (ri),
        .decode_en  (decode_en),
        .plan       (plan),
        .entry_step (entry_step)
    );

    exec_op_map exec_op_map_inst (
        .ri          (ri),
        .ind_flags   (ind_flags),
        .exec_alu    (exec_alu),
        .flag_update (flag_update),
        .mov_pass    (mov_pass)
    );

    reg_addr_sel reg_addr_sel_inst (
        .addr_step (addr_step),
        .dir       (plan.dir),
        .ri        (ri),
        .regs_addr (regs_addr)
    );

    uc_sequencer uc_sequencer_inst (
        .clk         (clk),
        .rst         (rst),
        .plan        (plan),
        .entry_step  (entry_step),
        .exec_alu    (exec_alu),
        .flag_update (flag_update),
        .mov_pass    (mov_pass),
        .decode_en   (decode_en),
        .addr_step   (addr_step),
        .bus         (bus),
        .alu         (alu),
        .state       (disp_state)
    );

endmodule

`default_nettype wire

// File: tests/uc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uc_config.svh"

module uc_tb;
    import uc_pkg::*;

    localparam int n_planned  = 26;  // tests in the run
    localparam int to_nothing = 0;
    localparam int to_reg     = 1;
    localparam int to_mem     = 2;

    logic                      clk;
    logic                      rst;
    instr_t                    ri;
    logic [`UC_WORD_WIDTH-1:0] ind_flags;
    bus_ctrl_t                 bus;
    alu_ctrl_t                 alu;
    reg_idx_t                  regs_addr;
    state_t                    disp_state;

    // instruction in flight
    logic [3:0] exp_op;
    logic       exp_carry;
    logic       exp_flag_we;
    logic       exp_mov;
    logic       exp_reserved;
    int         exp_store;
    logic [2:0] exp_store_addr;
    int         exp_cycles;    // 0 = not checked
    int         exp_n_addr;
    logic [2:0] exp_addr [0:1];

    int          test_errors;
    int          n_tests;
    int          n_bad;
    int          n_errors;

    logic [3:0] two_op_alu [0:6]   = '{ADC, ADC, SBB1, SBB1, AND, OR, XOR};
    string      two_op_name [0:6]  = '{"add", "adc", "sub", "sbb", "and", "or", "xor"};
    logic [3:0] one_op_alu [0:6]   = '{ADC, SBB1, SBB2, NOT, SHL, SHR, SAR};
    logic       one_op_carry [0:6] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    string      one_op_name [0:6]  = '{"inc", "dec", "neg", "not", "shl", "shr", "sar"};

    uc_top uc_top_inst (
        .clk        (clk),
        .rst        (rst),
        .ri         (ri),
        .ind_flags  (ind_flags),
        .bus        (bus),
        .alu        (alu),
        .regs_addr  (regs_addr),
        .disp_state (disp_state)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (n_planned * 40) @(posedge clk);
        $display("watchdog: the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // helpers
    function automatic bus_ctrl_t fetch_strobes(input int step);
        bus_ctrl_t b;
        b = '0;
        case (step)
            0: begin
                b.cp_oe = 1'b1;
                b.am_we = 1'b1;
            end
            1: b.am_oe = 1'b1;
            default: begin
                b.ram_oe = 1'b1;
                b.ri_we  = 1'b1;
            end
        endcase
        return b;
    endfunction

    function automatic instr_t random_word(input logic [6:0] cop, input logic [1:0] mode);
        instr_t w;
        w.cop  = cop;
        w.d    = 1'($urandom);
        w.mode = mode;
        w.rg   = 3'($urandom);
        w.rm   = 3'($urandom);
        return w;
    endfunction

    task automatic check_val(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("FAILED %s: %s expected 0x%0h actual 0x%0h", name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_true(input string name, input logic cond, input string what);
        assert (cond) else begin
            $display("%s: %s", name, what);
            test_errors++;
        end
    endtask

    task automatic set_expect(input logic [3:0] op, input logic carry, input logic flag_we,
                              input logic mov, input int store, input logic [2:0] store_addr);
        exp_op         = op;
        exp_carry      = carry;
        exp_flag_we    = flag_we;
        exp_mov        = mov;
        exp_store      = store;
        exp_store_addr = store_addr;
        exp_reserved   = 1'b0;
        exp_cycles     = 0;
        exp_n_addr     = 0;
    endtask

    task automatic expect_sum_addr(input instr_t word);
        exp_n_addr  = 2;
        exp_addr[0] = word.rm[1] ? BB : BA;
        exp_addr[1] = word.rm[2] ? XB : XA;
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        if (test_errors == 0) begin
            $display("ok      %s", name);
        end else begin
            $display("failed  %s, %0d checks", name, test_errors);
            n_bad++;
        end
        n_errors    += test_errors;
        test_errors = 0;
    endtask

    // entered at the falling edge of fetch2, leaves at the next fetch2
    task automatic run_instr(input string name, input instr_t word, input logic carry);
        int         cycles;
        int         done_at;
        int         n_cp_we;
        int         n_regs_we;
        int         n_ram_we;
        int         n_reads;
        logic       saw_exec;
        logic       saw_reset;
        logic [2:0] reads [0:1];
        cycles    = 3;  // fetch0..fetch2 behind us
        done_at   = 0;
        n_cp_we   = 0;
        n_regs_we = 0;
        n_ram_we  = 0;
        n_reads   = 0;
        saw_exec  = 1'b0;
        saw_reset = 1'b0;
        reads[0]  = '0;
        reads[1]  = '0;
        ri        = word;
        ind_flags = `UC_WORD_WIDTH'($urandom);
        ind_flags[0] = carry;
        do begin
            @(negedge clk);
            cycles++;
            case (disp_state)
                fetch0: check_val(name, "fetch0 strobes", 32'(fetch_strobes(0)), 32'(bus));
                fetch1: check_val(name, "fetch1 strobes", 32'(fetch_strobes(1)), 32'(bus));
                fetch2: check_val(name, "fetch2 strobes", 32'(fetch_strobes(2)), 32'(bus));
                exec_1op, exec_2op: begin
                    saw_exec = 1'b1;
                    check_val(name, "alu opcode", 32'(exp_op), 32'(alu.opcode));
                    check_val(name, "alu carry", 32'(exp_carry), 32'(alu.carry));
                    check_val(name, "ind_we", 32'(exp_flag_we), 32'(bus.ind_we));
                    if (exp_mov) begin
                        check_val(name, "t2_oe", 32'd1, 32'(bus.t2_oe));
                        check_val(name, "t1_oe", 32'd0, 32'(bus.t1_oe));
                    end
                end
                reset: begin
                    saw_reset = 1'b1;
                    check_val(name, "strobes in reset", 32'd0, 32'(bus));
                end
                decode: begin
                    if (exp_reserved) begin
                        check_val(name, "strobes in decode", 32'd0, 32'(bus));
                    end
                end
                default: ;
            endcase
            if (bus.regs_oe && n_reads < 2) begin
                reads[n_reads] = regs_addr;  // addressing reads come first
                n_reads++;
            end
            if (bus.regs_we) begin
                n_regs_we++;
                if (exp_store == to_reg) begin
                    check_val(name, "store address", 32'(exp_store_addr), 32'(regs_addr));
                end
            end
            if (bus.ram_we) begin
                n_ram_we++;
                check_true(name, bus.am_oe, "ram_we was raised without am_oe");
            end
            if (bus.cp_we) begin
                n_cp_we++;
                done_at = cycles;
            end
        end while (disp_state != fetch2 && cycles < 40);
        check_true(name, disp_state == fetch2, "the next fetch was never reached");
        check_val(name, "exec step", 32'(!exp_reserved), 32'(saw_exec));
        check_val(name, "reset step", 32'(exp_reserved), 32'(saw_reset));
        check_val(name, "cp_we count", exp_reserved ? 32'd0 : 32'd1, 32'(n_cp_we));
        check_val(name, "regs_we count", (exp_store == to_reg) ? 32'd1 : 32'd0, 32'(n_regs_we));
        check_val(name, "ram_we count", (exp_store == to_mem) ? 32'd1 : 32'd0, 32'(n_ram_we));
        if (exp_cycles != 0) begin
            check_val(name, "cycles to cp_we", 32'(exp_cycles), 32'(done_at));
        end
        if (exp_n_addr > 0) begin
            check_val(name, "first address register", 32'(exp_addr[0]), 32'(reads[0]));
        end
        if (exp_n_addr > 1) begin
            check_val(name, "second address register", 32'(exp_addr[1]), 32'(reads[1]));
        end
        finish_test(name);
    endtask

    task automatic run_reserved(input string name, input logic [6:0] cop,
                                input logic [1:0] mode);
        instr_t word;
        word = random_word(cop, mode);
        set_expect(4'd0, 1'b0, 1'b0, 1'b0, to_nothing, 3'd0);
        exp_reserved = 1'b1;
        run_instr(name, word, 1'($urandom));
    endtask

    //////////////////////////////////////////////////
    // test sequence
    initial begin
        instr_t word;
        logic   carry;
        rst         = 1'b0;
        ri          = '0;
        ind_flags   = '0;
        test_errors = 0;
        n_tests     = 0;
        n_bad       = 0;
        n_errors    = 0;
        void'($urandom(44));

        repeat (10) begin
            @(negedge clk);
            check_val("reset_fetch", "strobes in reset", 32'd0, 32'(bus));
            check_val("reset_fetch", "alu in reset", 32'd0, 32'(alu));
        end
        rst = 1'b1;
        for (int step = 0; step < 3; step++) begin
            @(negedge clk);
            check_val("reset_fetch", "fetch strobes", 32'(fetch_strobes(step)), 32'(bus));
        end
        check_val("reset_fetch", "state", 32'(fetch2), 32'(disp_state));
        finish_test("reset_fetch");

        for (int i = 0; i < 7; i++) begin
            word  = random_word(7'b0101000 | 7'(i), 2'b11);
            carry = 1'($urandom);
            set_expect(two_op_alu[i], (i == 1 || i == 3) ? carry : 1'b0, 1'b1, 1'b0,
                       to_reg, word.d ? word.rg : word.rm);
            exp_cycles = 10;
            run_instr(two_op_name[i], word, carry);
        end

        word = random_word(7'b0100010, 2'b11);  // cmp keeps only the flags
        set_expect(SBB1, 1'b0, 1'b1, 1'b0, to_nothing, 3'd0);
        run_instr("cmp", word, 1'($urandom));
        word = random_word(7'b0100100, 2'b11);
        set_expect(AND, 1'b0, 1'b1, 1'b0, to_nothing, 3'd0);
        run_instr("test", word, 1'($urandom));

        for (int i = 0; i < 7; i++) begin
            word   = random_word(7'b0001000 | 7'(i), 2'b11);
            word.d = 1'b0;  // operand in rm
            set_expect(one_op_alu[i], one_op_carry[i], 1'b1, 1'b0, to_reg, word.rm);
            run_instr(one_op_name[i], word, 1'($urandom));
        end

        word = random_word(7'b0000000, 2'b11);
        set_expect(OR, 1'b0, 1'b0, 1'b1, to_reg, word.d ? word.rg : word.rm);
        exp_cycles = 10;
        run_instr("mov", word, 1'($urandom));

        // memory operands, mod 00
        word       = random_word(7'b0101000, 2'b00);
        word.d     = 1'b0;
        word.rm[0] = 1'b0;
        set_expect(ADC, 1'b0, 1'b1, 1'b0, to_mem, 3'd0);
        expect_sum_addr(word);
        run_instr("mem_base_index", word, 1'($urandom));

        word       = random_word(7'b0101010, 2'b00);
        word.d     = 1'b1;
        word.rm[0] = 1'b0;
        set_expect(SBB1, 1'b0, 1'b1, 1'b0, to_reg, word.rg);
        expect_sum_addr(word);
        run_instr("mem_to_reg", word, 1'($urandom));

        word       = random_word(7'b0101110, 2'b00);
        word.d     = 1'b0;
        word.rm[0] = 1'b1;
        set_expect(XOR, 1'b0, 1'b1, 1'b0, to_mem, 3'd0);
        exp_n_addr  = 1;
        exp_addr[0] = word.rm;
        run_instr("mem_indirect", word, 1'($urandom));

        word       = random_word(7'b0001000, 2'b00);
        word.d     = 1'b0;
        word.rm[0] = 1'b1;
        set_expect(ADC, 1'b1, 1'b1, 1'b0, to_mem, 3'd0);
        exp_n_addr  = 1;
        exp_addr[0] = word.rm;
        run_instr("mem_inc", word, 1'($urandom));

        run_reserved("mod01", 7'b0101000, 2'b01);
        run_reserved("mod10", 7'b0101101, 2'b10);
        run_reserved("push", 7'b0000001, 2'b11);
        run_reserved("pop", 7'b0000010, 2'b11);

        $display("%0d tests, %0d failed, %0d failed checks", n_tests, n_bad, n_errors);
        if (n_bad == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verilog
verilog/uc_pkg.sv
verilog/instr_decoder.sv
verilog/exec_op_map.sv
verilog/reg_addr_sel.sv
verilog/uc_sequencer.sv
verilog/uc_top.sv
tests/uc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the control unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module uc_tb -f verilog.f

out=$(./obj_dir/Vuc_tb)
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1
